/* source/cong_man_pkg.sv */
// Congestion manager shared sizes and types
`default_nettype none

package cong_man_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_EGR_PORTS   = 4;
    localparam int QUEUES_PER_PORT = 2;
    localparam int NUM_QUEUES      = NUM_EGR_PORTS * QUEUES_PER_PORT;

    // Priorities from here up use the high queue of a port
    localparam int HIGH_PRIO_MIN   = 6;

    localparam int DATA_BYTES      = 16;
    localparam int BYTES_PER_PAGE  = 256;
    localparam int WORDS_PER_PAGE  = BYTES_PER_PAGE / DATA_BYTES;
    localparam int NUM_PAGES       = 16;
    localparam int MEM_BYTES       = NUM_PAGES * BYTES_PER_PAGE;
    localparam int MTU_BYTES       = 1500;

    // Descriptor field widths
    localparam int EGR_PORT_BITS   = 4;
    localparam int PRIO_BITS       = 3;

    ////////////////////////////////////////////////////////////
    // Field types

    typedef logic [$clog2(NUM_QUEUES)-1:0]     queue_idx_t;
    typedef logic [$clog2(NUM_PAGES)-1:0]      page_idx_t;
    // One extra bit so a full pool can be counted
    typedef logic [$clog2(NUM_PAGES):0]        page_count_t;
    typedef logic [$clog2(WORDS_PER_PAGE)-1:0] word_ptr_t;
    typedef logic [$clog2(MTU_BYTES+1)-1:0]    byte_len_t;
    typedef logic [$clog2(MEM_BYTES+1)-1:0]    occ_t;

    ////////////////////////////////////////////////////////////
    // Structs

    // Incoming packet descriptor
    typedef struct packed {
        logic [EGR_PORT_BITS-1:0] egr_port;
        logic [PRIO_BITS-1:0]     prio;
        byte_len_t                byte_len;
        logic                     drop_mark;
    } pkt_desc_t;

    // Per-queue enqueue state
    typedef struct packed {
        occ_t      occupancy;
        word_ptr_t tail_ptr;
        page_idx_t cur_page;
        logic      page_valid;
    } queue_state_t;

    // Listed in rule priority order
    typedef enum logic [1:0] {
        NONE,
        QUEUE_FULL,
        POLICER,
        NO_PAGES
    } drop_reason_t;

    // Admission result, one per descriptor
    typedef struct packed {
        logic         accept;
        drop_reason_t reason;
        queue_idx_t   queue;
        word_ptr_t    new_tail;
        logic         malloc;
        page_idx_t    page;
    } verdict_t;

endpackage

`default_nettype wire

/* source/queue_table.sv */
// Per-queue register file
`default_nettype none
`timescale 1ns/100ps

module queue_table #(
    parameter type    entry_t     = cong_man_pkg::occ_t,
    parameter entry_t RESET_ENTRY = '0
) (
    input  wire                           core_clk_ifc,
    input  wire                           arst_n,

    // Read port, data one cycle after the address
    input  wire cong_man_pkg::queue_idx_t rd_queue,
    output entry_t                        rd_entry,

    // Write port
    input  wire                           wr_valid,
    input  wire cong_man_pkg::queue_idx_t wr_queue,
    input  wire entry_t                   wr_entry
);

    ////////////////////////////////////////////////////////////
    // Storage

    // One entry per queue
    entry_t entries [cong_man_pkg::NUM_QUEUES];

    // Every entry starts from a known value, thresholds and
    // queue state alike
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            for (int q = 0; q < cong_man_pkg::NUM_QUEUES; q++) begin
                entries[q] <= RESET_ENTRY;
            end
        end else if (wr_valid) begin
            entries[wr_queue] <= wr_entry;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered read

    // Same-edge write is not visible here, old data comes out
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rd_entry <= RESET_ENTRY;
        end else begin
            rd_entry <= entries[rd_queue];
        end
    end

endmodule

`default_nettype wire

/* source/page_allocator.sv */
// Free page pool
`default_nettype none
`timescale 1ns/100ps

module page_allocator (
    input  wire                            core_clk_ifc,
    input  wire                            arst_n,

    // Allocation, page is valid before the request edge
    input  wire                            alloc,
    output cong_man_pkg::page_idx_t        alloc_page,

    // Returned pages
    input  wire                            release_valid,
    input  wire cong_man_pkg::page_idx_t   release_page,

    output cong_man_pkg::page_count_t      free_count
);

    ////////////////////////////////////////////////////////////
    // Fresh pages

    // Next never-used page, reaches NUM_PAGES once all are out
    cong_man_pkg::page_count_t fresh_next;
    logic                      fresh_avail;

    assign fresh_avail = fresh_next < cong_man_pkg::page_count_t'(cong_man_pkg::NUM_PAGES);

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            fresh_next <= '0;
        end else if (alloc && fresh_avail) begin
            fresh_next <= fresh_next + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Returned page FIFO

    // Depth covers every page, pointers wrap on their own
    cong_man_pkg::page_idx_t ret_fifo [cong_man_pkg::NUM_PAGES];
    cong_man_pkg::page_idx_t ret_rd_ptr;
    cong_man_pkg::page_idx_t ret_wr_ptr;

    always_ff @(posedge core_clk_ifc) begin
        if (release_valid) begin
            ret_fifo[ret_wr_ptr] <= release_page;
        end
    end

    // FIFO cannot be empty here, a nonzero free count with
    // no fresh pages left means pages were returned
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            ret_rd_ptr <= '0;
            ret_wr_ptr <= '0;
        end else begin
            if (release_valid) begin
                ret_wr_ptr <= ret_wr_ptr + 1'b1;
            end
            if (alloc && !fresh_avail) begin
                ret_rd_ptr <= ret_rd_ptr + 1'b1;
            end
        end
    end

    assign alloc_page = fresh_avail ? cong_man_pkg::page_idx_t'(fresh_next)
                                    : ret_fifo[ret_rd_ptr];

    ////////////////////////////////////////////////////////////
    // Free count

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            free_count <= cong_man_pkg::page_count_t'(cong_man_pkg::NUM_PAGES);
        end else begin
            case ({alloc, release_valid})
                2'b10:   free_count <= free_count - 1'b1;
                2'b01:   free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/admission_ctrl.sv */
// Admission pipeline
`default_nettype none
`timescale 1ns/100ps

module admission_ctrl (
    input  wire                              core_clk_ifc,
    input  wire                              arst_n,

    input  wire                              desc_valid,
    input  wire cong_man_pkg::pkt_desc_t     desc,

    // Table reads, shared address
    output cong_man_pkg::queue_idx_t         rd_queue,
    input  wire cong_man_pkg::occ_t          thresh,
    input  wire cong_man_pkg::queue_state_t  state,

    // State write back
    output logic                             state_wr_valid,
    output cong_man_pkg::queue_idx_t         state_wr_queue,
    output cong_man_pkg::queue_state_t       state_wr,

    // Page pool
    output logic                             alloc,
    input  wire cong_man_pkg::page_idx_t     alloc_page,
    input  wire cong_man_pkg::page_count_t   free_count,

    output logic                             verdict_valid,
    output cong_man_pkg::verdict_t           verdict
);

    logic                        desc_high;
    logic                        s1_valid;
    cong_man_pkg::pkt_desc_t     s1_desc;
    cong_man_pkg::queue_idx_t    s1_queue;
    logic                        fwd_valid;
    cong_man_pkg::queue_state_t  fwd_state;

    cong_man_pkg::queue_state_t  cur_state;
    cong_man_pkg::queue_state_t  nxt_state;
    cong_man_pkg::occ_t          words;
    cong_man_pkg::occ_t          tail_sum;
    logic [$bits(cong_man_pkg::occ_t):0] occ_sum;
    cong_man_pkg::page_count_t   occ_pages;
    logic                        need_malloc;
    logic                        accept;
    cong_man_pkg::drop_reason_t  reason;

    ////////////////////////////////////////////////////////////
    // Stage 1, queue lookup while the tables read

    assign desc_high = desc.prio >= cong_man_pkg::HIGH_PRIO_MIN;
    assign rd_queue  = cong_man_pkg::queue_idx_t'(
        desc.egr_port * cong_man_pkg::QUEUES_PER_PORT + desc_high);

    // Table read misses a write on the same edge, so catch it
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            s1_valid  <= desc_valid;
            fwd_valid <= desc_valid && state_wr_valid && (rd_queue == state_wr_queue);
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        s1_desc   <= desc;
        s1_queue  <= rd_queue;
        fwd_state <= state_wr;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, drop rules

    // Pool outputs come from its registers and already hold
    // the previous packet's allocation
    assign cur_state = fwd_valid ? fwd_state : state;

    // Length in buffer words, rounded up
    assign words = (cong_man_pkg::occ_t'(s1_desc.byte_len) +
                    cong_man_pkg::occ_t'(cong_man_pkg::DATA_BYTES - 1)) /
                   cong_man_pkg::occ_t'(cong_man_pkg::DATA_BYTES);
    assign tail_sum  = cong_man_pkg::occ_t'(cur_state.tail_ptr) + words;
    assign occ_sum   = {1'b0, cur_state.occupancy} + s1_desc.byte_len;
    assign occ_pages = cong_man_pkg::page_count_t'(
        cur_state.occupancy / cong_man_pkg::BYTES_PER_PAGE);

    assign need_malloc = !cur_state.page_valid ||
                         (tail_sum >= cong_man_pkg::occ_t'(cong_man_pkg::WORDS_PER_PAGE));

    // First matching rule wins
    always_comb begin
        if (occ_sum > {1'b0, thresh}) begin
            reason = cong_man_pkg::QUEUE_FULL;
        end else if (s1_desc.drop_mark && (s1_desc.prio < cong_man_pkg::HIGH_PRIO_MIN)) begin
            reason = cong_man_pkg::POLICER;
        end else if (need_malloc && ((occ_pages > free_count) || (free_count == '0))) begin
            reason = cong_man_pkg::NO_PAGES;
        end else begin
            reason = cong_man_pkg::NONE;
        end
    end

    assign accept = (reason == cong_man_pkg::NONE);

    // Dropped packets leave the queue untouched
    always_comb begin
        nxt_state = cur_state;
        if (accept) begin
            nxt_state.occupancy = cong_man_pkg::occ_t'(occ_sum);
            nxt_state.tail_ptr  = cong_man_pkg::word_ptr_t'(
                tail_sum % cong_man_pkg::WORDS_PER_PAGE);
            if (need_malloc) begin
                nxt_state.cur_page   = alloc_page;
                nxt_state.page_valid = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Write back and verdict

    assign state_wr_valid = s1_valid && accept;
    assign state_wr_queue = s1_queue;
    assign state_wr       = nxt_state;
    assign alloc          = state_wr_valid && need_malloc;

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= s1_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        verdict.accept   <= accept;
        verdict.reason   <= reason;
        verdict.queue    <= s1_queue;
        verdict.new_tail <= nxt_state.tail_ptr;
        verdict.malloc   <= accept && need_malloc;
        verdict.page     <= nxt_state.cur_page;
    end

endmodule

`default_nettype wire

/* source/congestion_manager.sv */
// Congestion manager top level
`default_nettype none
`timescale 1ns/100ps

module congestion_manager (
    input  wire                            core_clk_ifc,
    input  wire                            arst_n,

    // Drop threshold configuration
    input  wire                            cfg_valid,
    input  wire cong_man_pkg::queue_idx_t  cfg_queue,
    input  wire cong_man_pkg::occ_t        cfg_thresh,

    input  wire                            desc_valid,
    input  wire cong_man_pkg::pkt_desc_t   desc,

    input  wire                            page_release_valid,
    input  wire cong_man_pkg::page_idx_t   page_release,

    output logic                           verdict_valid,
    output cong_man_pkg::verdict_t         verdict,
    output cong_man_pkg::page_count_t      num_free_pages
);

    cong_man_pkg::queue_idx_t   rd_queue;
    cong_man_pkg::occ_t         thresh;
    cong_man_pkg::queue_state_t state;
    logic                       state_wr_valid;
    cong_man_pkg::queue_idx_t   state_wr_queue;
    cong_man_pkg::queue_state_t state_wr;
    logic                       alloc;
    cong_man_pkg::page_idx_t    alloc_page;

    ////////////////////////////////////////////////////////////
    // Queue tables

    // Thresholds start at the whole buffer
    queue_table #(
        .entry_t     (cong_man_pkg::occ_t),
        .RESET_ENTRY (cong_man_pkg::occ_t'(cong_man_pkg::MEM_BYTES))
    ) u_thresh_table (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .rd_queue     (rd_queue),
        .rd_entry     (thresh),
        .wr_valid     (cfg_valid),
        .wr_queue     (cfg_queue),
        .wr_entry     (cfg_thresh)
    );

    // Empty queues with no page
    queue_table #(
        .entry_t     (cong_man_pkg::queue_state_t),
        .RESET_ENTRY (cong_man_pkg::queue_state_t'('0))
    ) u_state_table (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .rd_queue     (rd_queue),
        .rd_entry     (state),
        .wr_valid     (state_wr_valid),
        .wr_queue     (state_wr_queue),
        .wr_entry     (state_wr)
    );

    ////////////////////////////////////////////////////////////
    // Page pool and admission

    page_allocator u_page_alloc (
        .core_clk_ifc  (core_clk_ifc),
        .arst_n        (arst_n),
        .alloc         (alloc),
        .alloc_page    (alloc_page),
        .release_valid (page_release_valid),
        .release_page  (page_release),
        .free_count    (num_free_pages)
    );

    admission_ctrl u_admission (
        .core_clk_ifc   (core_clk_ifc),
        .arst_n         (arst_n),
        .desc_valid     (desc_valid),
        .desc           (desc),
        .rd_queue       (rd_queue),
        .thresh         (thresh),
        .state          (state),
        .state_wr_valid (state_wr_valid),
        .state_wr_queue (state_wr_queue),
        .state_wr       (state_wr),
        .alloc          (alloc),
        .alloc_page     (alloc_page),
        .free_count     (num_free_pages),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict)
    );

endmodule

`default_nettype wire

/* testbench/congestion_manager_tb.sv */
// Congestion manager testbench
`default_nettype none
`timescale 1ns/100ps

module congestion_manager_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 300;
    localparam int MAX_RECORDS  = 256;

    logic                       core_clk_ifc;
    logic                       arst_n;
    logic                       cfg_valid;
    cong_man_pkg::queue_idx_t   cfg_queue;
    cong_man_pkg::occ_t         cfg_thresh;
    logic                       desc_valid;
    cong_man_pkg::pkt_desc_t    desc;
    logic                       page_release_valid;
    cong_man_pkg::page_idx_t    page_release;
    logic                       verdict_valid;
    cong_man_pkg::verdict_t     verdict;
    cong_man_pkg::page_count_t  num_free_pages;

    cong_man_pkg::verdict_t     exp_q [$];
    cong_man_pkg::verdict_t     exp_head;
    int                         errors;
    int                         checks;
    int                         test_err_start;
    int                         num_tests;
    logic                       records_loaded;
    int                         n_rec;
    byte                        rec_op  [MAX_RECORDS];
    int                         rec_arg [MAX_RECORDS][10];
    logic [31:0]                rng;

    // Reference model of queue state and page pool
    cong_man_pkg::occ_t         m_occ    [cong_man_pkg::NUM_QUEUES];
    cong_man_pkg::word_ptr_t    m_tail   [cong_man_pkg::NUM_QUEUES];
    cong_man_pkg::page_idx_t    m_page   [cong_man_pkg::NUM_QUEUES];
    logic                       m_pvalid [cong_man_pkg::NUM_QUEUES];
    int                         m_fresh;
    int                         m_free;
    cong_man_pkg::page_idx_t    m_returned [$];
    cong_man_pkg::page_idx_t    m_held [$];

    congestion_manager u_dut (
        .core_clk_ifc       (core_clk_ifc),
        .arst_n             (arst_n),
        .cfg_valid          (cfg_valid),
        .cfg_queue          (cfg_queue),
        .cfg_thresh         (cfg_thresh),
        .desc_valid         (desc_valid),
        .desc               (desc),
        .page_release_valid (page_release_valid),
        .page_release       (page_release),
        .verdict_valid      (verdict_valid),
        .verdict            (verdict),
        .num_free_pages     (num_free_pages)
    );

    initial core_clk_ifc = 1'b0;
    always #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_reason(input cong_man_pkg::drop_reason_t got,
                                input cong_man_pkg::drop_reason_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t verdict.reason got %s expected %s",
                     $time, got.name(), exp.name());
        end
    endtask

    task automatic check_verdict(input cong_man_pkg::verdict_t got,
                                 input cong_man_pkg::verdict_t exp);
        cong_man_pkg::verdict_t masked;
        masked        = got;
        masked.reason = exp.reason;
        check_reason(got.reason, exp.reason);
        checks++;
        if (masked !== exp) begin
            errors++;
            $display("[FAIL] %0t verdict got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input cong_man_pkg::page_count_t got,
                               input cong_man_pkg::page_count_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Verdicts are sampled on the edge where verdict_valid is high
    always @(posedge core_clk_ifc) begin
        if (arst_n === 1'b1 && verdict_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("At %0t a verdict came out with no descriptor waiting for one", $time);
            end else begin
                exp_head = exp_q.pop_front();
                check_verdict(verdict, exp_head);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Drive helpers

    task automatic next_cycle();
        @(posedge core_clk_ifc);
        #DRIVE_DELAY;
        cfg_valid          = 1'b0;
        desc_valid         = 1'b0;
        page_release_valid = 1'b0;
    endtask

    task automatic drain();
        next_cycle();
        while (exp_q.size() != 0) begin
            @(posedge core_clk_ifc);
            #1;
        end
    endtask

    task automatic apply_reset();
        @(posedge core_clk_ifc);
        #DRIVE_DELAY;
        arst_n             = 1'b0;
        cfg_valid          = 1'b0;
        desc_valid         = 1'b0;
        page_release_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk_ifc);
        #DRIVE_DELAY;
        arst_n = 1'b1;
    endtask

    task automatic check_reset_state();
        checks++;
        if (verdict_valid !== 1'b0) begin
            errors++;
            $display("[FAIL] %0t verdict_valid got %b expected 0", $time, verdict_valid);
        end
        check_count(num_free_pages, cong_man_pkg::NUM_PAGES, "num_free_pages");
    endtask

    task automatic report_test(input int id, input string name);
        num_tests++;
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            $display("test %0d %s: %0d errors", id, name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "threshold drops";
            2:       return "policer drops";
            3:       return "tail pointer and allocation";
            4:       return "pool exhaustion and release";
            default: return "directed";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic model_reset();
        for (int q = 0; q < cong_man_pkg::NUM_QUEUES; q++) begin
            m_occ[q]    = '0;
            m_tail[q]   = '0;
            m_page[q]   = '0;
            m_pvalid[q] = 1'b0;
        end
        m_fresh = 0;
        m_free  = cong_man_pkg::NUM_PAGES;
        m_returned.delete();
        m_held.delete();
    endtask

    // Thresholds stay at their reset value in the random phase
    task automatic model_admit(input cong_man_pkg::pkt_desc_t d,
                               output cong_man_pkg::verdict_t v);
        int q;
        int words;
        int tail_sum;
        logic need;
        cong_man_pkg::page_idx_t pg;
        q        = d.egr_port * 2 + ((d.prio > 5) ? 1 : 0);
        words    = (d.byte_len + cong_man_pkg::DATA_BYTES - 1) / cong_man_pkg::DATA_BYTES;
        tail_sum = m_tail[q] + words;
        need     = !m_pvalid[q] || (tail_sum >= cong_man_pkg::WORDS_PER_PAGE);
        v          = '0;
        v.queue    = q;
        v.new_tail = m_tail[q];
        v.page     = m_page[q];
        if (m_occ[q] + d.byte_len > cong_man_pkg::MEM_BYTES) begin
            v.reason = cong_man_pkg::QUEUE_FULL;
        end else if (d.drop_mark && d.prio < 6) begin
            v.reason = cong_man_pkg::POLICER;
        end else if (need && ((m_occ[q] / cong_man_pkg::BYTES_PER_PAGE > m_free) ||
                              m_free == 0)) begin
            v.reason = cong_man_pkg::NO_PAGES;
        end else begin
            v.reason  = cong_man_pkg::NONE;
            v.accept  = 1'b1;
            m_occ[q]  = m_occ[q] + d.byte_len;
            m_tail[q] = tail_sum % cong_man_pkg::WORDS_PER_PAGE;
            if (need) begin
                if (m_fresh < cong_man_pkg::NUM_PAGES) begin
                    pg = m_fresh;
                    m_fresh++;
                end else begin
                    pg = m_returned.pop_front();
                end
                m_free--;
                m_held.push_back(pg);
                m_page[q]   = pg;
                m_pvalid[q] = 1'b1;
                v.malloc    = 1'b1;
            end
            v.new_tail = m_tail[q];
            v.page     = m_page[q];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pattern file

    task automatic load_patterns();
        int fd;
        int code;
        byte op;
        logic [8*256-1:0] skip_line;
        n_rec = 0;
        fd = $fopen("testbench/cong_man_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file");
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(skip_line, fd);
                end else if (op == "D") begin
                    code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d",
                        rec_arg[n_rec][0], rec_arg[n_rec][1], rec_arg[n_rec][2],
                        rec_arg[n_rec][3], rec_arg[n_rec][4], rec_arg[n_rec][5],
                        rec_arg[n_rec][6], rec_arg[n_rec][7], rec_arg[n_rec][8],
                        rec_arg[n_rec][9]);
                    rec_op[n_rec] = op;
                    n_rec++;
                end else if (op == "C") begin
                    code = $fscanf(fd, "%d %d", rec_arg[n_rec][0], rec_arg[n_rec][1]);
                    rec_op[n_rec] = op;
                    n_rec++;
                end else begin
                    code = $fscanf(fd, "%d", rec_arg[n_rec][0]);
                    rec_op[n_rec] = op;
                    n_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_record(input int r);
        cong_man_pkg::verdict_t v;
        case (rec_op[r])
            "C": begin
                next_cycle();
                cfg_valid  = 1'b1;
                cfg_queue  = rec_arg[r][0];
                cfg_thresh = rec_arg[r][1];
            end
            "R": begin
                next_cycle();
                page_release_valid = 1'b1;
                page_release       = rec_arg[r][0];
            end
            "D": begin
                next_cycle();
                desc.egr_port  = rec_arg[r][0];
                desc.prio      = rec_arg[r][1];
                desc.byte_len  = rec_arg[r][2];
                desc.drop_mark = rec_arg[r][3];
                v.accept   = rec_arg[r][4];
                v.reason   = cong_man_pkg::drop_reason_t'(rec_arg[r][5]);
                v.queue    = rec_arg[r][6];
                v.new_tail = rec_arg[r][7];
                v.malloc   = rec_arg[r][8];
                v.page     = rec_arg[r][9];
                exp_q.push_back(v);
                desc_valid = 1'b1;
            end
            "I": repeat (rec_arg[r][0]) next_cycle();
            "F": begin
                drain();
                check_count(num_free_pages, rec_arg[r][0], "num_free_pages");
            end
            "E": begin
                drain();
                report_test(rec_arg[r][0], test_name(rec_arg[r][0]));
            end
            default: begin
                errors++;
                $display("Unknown record type in the pattern file");
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Random phase

    task automatic run_random();
        int n_desc;
        int idx;
        cong_man_pkg::page_idx_t pg;
        cong_man_pkg::verdict_t v;
        n_desc = 0;
        while (n_desc < NUM_RANDOM) begin
            next_cycle();
            rng = xorshift(rng);
            // Pool counts a release before this descriptor's decision
            if (rng[2:0] == 3'd0 && m_held.size() != 0) begin
                idx = (rng >> 8) % m_held.size();
                pg  = m_held[idx];
                m_held.delete(idx);
                m_returned.push_back(pg);
                m_free++;
                page_release_valid = 1'b1;
                page_release       = pg;
            end
            if (rng[5:4] != 2'd0) begin
                desc.egr_port  = {2'b00, rng[17:16]};
                desc.prio      = rng[20:18];
                desc.drop_mark = rng[9] & rng[10];
                if (rng[23:21] == 3'd0) begin
                    desc.byte_len = (rng[31:16] % cong_man_pkg::MTU_BYTES) + 1;
                end else begin
                    desc.byte_len = rng[31:24] + 1;
                end
                model_admit(desc, v);
                exp_q.push_back(v);
                desc_valid = 1'b1;
                n_desc++;
            end
        end
        next_cycle();
        drain();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        arst_n             = 1'b1;
        cfg_valid          = 1'b0;
        cfg_queue          = '0;
        cfg_thresh         = '0;
        desc_valid         = 1'b0;
        desc               = '0;
        page_release_valid = 1'b0;
        page_release       = '0;
        errors             = 0;
        checks             = 0;
        test_err_start     = 0;
        num_tests          = 0;
        records_loaded     = 1'b0;
        rng                = 32'd94;
        load_patterns();
        records_loaded = 1'b1;

        apply_reset();
        check_reset_state();
        report_test(6, "reset state");

        for (int r = 0; r < n_rec; r++) begin
            run_record(r);
        end

        apply_reset();
        model_reset();
        check_reset_state();
        run_random();
        report_test(5, "random mix");

        $display("tests %0d checks %0d errors %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (records_loaded === 1'b1);
        #((n_rec + NUM_RANDOM) * 4 * CLK_PERIOD + 1000 * CLK_PERIOD);
        $display("Run stopped by the watchdog, verdicts did not arrive in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* congestion_manager.f */
source/cong_man_pkg.sv
source/queue_table.sv
source/page_allocator.sv
source/admission_ctrl.sv
source/congestion_manager.sv
testbench/congestion_manager_tb.sv

/* Bender.yml */
package:
  name: congestion_manager

sources:
  - source/cong_man_pkg.sv
  - source/queue_table.sv
  - source/page_allocator.sv
  - source/admission_ctrl.sv
  - source/congestion_manager.sv
  - target: test
    files:
      - testbench/congestion_manager_tb.sv

/* testbench/cong_man_patterns.txt */
# C queue thresh | R page | I cycles | F exp_free_pages | E test_id
# D port prio len mark exp_accept exp_reason exp_queue exp_tail exp_malloc exp_page
C 0 1024
C 1 512
D 0 0 1024 0 1 0 0 0 1 0
D 0 0 1 0 0 1 0 0 0 0
D 0 6 512 0 1 0 1 0 1 1
D 0 7 1 0 0 1 1 0 0 1
I 3
E 1
D 1 5 100 1 0 2 2 0 0 0
D 1 6 100 1 1 0 3 7 1 2
D 1 5 100 0 1 0 2 7 1 3
D 1 0 32 0 1 0 2 9 0 3
I 3
E 2
D 2 1 16 0 1 0 4 1 1 4
D 2 1 160 0 1 0 4 11 0 4
D 2 1 80 0 1 0 4 0 1 5
D 2 1 48 0 1 0 4 3 0 5
D 2 2 250 0 1 0 4 3 1 6
D 2 2 256 0 1 0 4 3 1 7
F 8
E 3
D 3 0 256 0 1 0 6 0 1 8
D 3 0 256 0 1 0 6 0 1 9
D 3 0 256 0 1 0 6 0 1 10
D 3 0 256 0 1 0 6 0 1 11
D 3 0 256 0 1 0 6 0 1 12
D 3 6 256 0 1 0 7 0 1 13
D 3 6 256 0 1 0 7 0 1 14
D 2 6 256 0 1 0 5 0 1 15
D 2 6 256 0 0 3 5 0 0 15
F 0
R 3
R 7
F 2
D 2 6 256 0 1 0 5 0 1 3
D 1 6 256 0 1 0 3 7 1 7
F 0
E 4
